//--- logic/exu_pkg.sv
`default_nettype none

package exu_pkg;

    // sizes shared across the execution unit
    localparam int ADDRESS_WIDTH = 20;
    localparam int DATA_WIDTH = 16;
    localparam int REG_COUNT = 8;
    localparam int UOP_ROM_DEPTH = 512;

    // command toward the bus control unit
    typedef enum logic [1:0]
    {
        BUS_IDLE  = 2'd0,
        BUS_READ  = 2'd1,
        BUS_WRITE = 2'd2
    } bus_command_t;

    // move locations as coded in the micro-op word
    typedef enum logic [4:0]
    {
        LOC_NONE = 5'h00,
        // register named by the reg field of modrm
        LOC_R    = 5'h01,
        // register or memory named by mod and rm
        LOC_RM   = 5'h02,
        // immediate bytes of the instruction, source only
        LOC_IMM  = 5'h03,
        LOC_AL   = 5'h04,
        LOC_AH   = 5'h08,
        LOC_AW   = 5'h0c,
        LOC_CW   = 5'h0d,
        LOC_DW   = 5'h0e,
        LOC_BW   = 5'h0f,
        LOC_SP   = 5'h10,
        LOC_BP   = 5'h11,
        LOC_IX   = 5'h12,
        LOC_IY   = 5'h13
    } micro_loc_t;

    // micro-op classes, only move is carried out here
    typedef enum logic [2:0]
    {
        UOP_NONE = 3'b000,
        UOP_MOVE = 3'b001
    } micro_type_t;

    // segment register picked for a memory operand
    typedef enum logic [1:0]
    {
        SEG_ES = 2'd0,
        SEG_CS = 2'd1,
        SEG_SS = 2'd2,
        SEG_DS = 2'd3
    } segment_sel_t;

    typedef struct packed
    {
        micro_type_t op_type;
        logic [6:0]  arg;
        logic        last;
        micro_loc_t  dst;
        micro_loc_t  src;
    } micro_op_t;

    typedef struct packed
    {
        logic [7:0]  opcode;
        logic [7:0]  modrm;
        logic [15:0] disp;
        logic [15:0] imm;
    } instruction_t;

    typedef struct packed
    {
        logic         need_modrm;
        logic         need_disp;
        logic         disp_word;
        logic         need_imm;
        logic         imm_word;
        logic         word;
        logic [2:0]   src_reg;
        logic [2:0]   dst_reg;
        logic         mem_operand;
        // top bit set means the term is left out
        logic [3:0]   base_sel;
        logic [3:0]   index_sel;
        segment_sel_t segment;
    } decoded_t;

    typedef struct packed
    {
        bus_command_t                command;
        logic [ADDRESS_WIDTH-1:0]    address;
        logic [DATA_WIDTH-1:0]       write_data;
        logic                        word;
    } bus_request_t;

    typedef struct packed
    {
        logic [15:0] es;
        logic [15:0] cs;
        logic [15:0] ss;
        logic [15:0] ds;
    } segment_set_t;

endpackage

`default_nettype wire

//--- logic/instruction_fetch.sv
`default_nettype none

module instruction_fetch
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire [7:0]             prefetch_data,
    input  wire                   queue_empty,
    input  wire exu_pkg::decoded_t dec,
    input  wire                   step_done,
    output logic                  queue_pop,
    output exu_pkg::instruction_t instr,
    output logic                  exec_valid
);

    typedef enum logic [2:0]
    {
        FETCH_OPCODE,
        FETCH_MODRM,
        FETCH_DISP_LOW,
        FETCH_DISP_HIGH,
        FETCH_IMM_LOW,
        FETCH_IMM_HIGH,
        FETCH_EXECUTE
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t next_state;
    fetch_state_t after_disp;
    exu_pkg::instruction_t instr_q;
    // low while in reset, keeps the queue untouched until the unit runs
    logic active;

    // byte being taken this cycle is already visible to the decoder
    always_comb
    begin
        instr = instr_q;
        case (state)
            FETCH_OPCODE:    instr.opcode = prefetch_data;
            FETCH_MODRM:     instr.modrm = prefetch_data;
            FETCH_DISP_LOW:  instr.disp[7:0] = prefetch_data;
            FETCH_DISP_HIGH: instr.disp[15:8] = prefetch_data;
            FETCH_IMM_LOW:   instr.imm[7:0] = prefetch_data;
            FETCH_IMM_HIGH:  instr.imm[15:8] = prefetch_data;
            default:         instr = instr_q;
        endcase
    end

    assign queue_pop = active && (state != FETCH_EXECUTE) && !queue_empty;
    assign exec_valid = (state == FETCH_EXECUTE);

    // where to go once the displacement is done or skipped
    assign after_disp = dec.need_imm ? FETCH_IMM_LOW : FETCH_EXECUTE;

    always_comb
    begin
        next_state = state;
        case (state)
            FETCH_OPCODE:
                next_state = dec.need_modrm ? FETCH_MODRM : after_disp;
            FETCH_MODRM:
                next_state = dec.need_disp ? FETCH_DISP_LOW : after_disp;
            FETCH_DISP_LOW:
                next_state = dec.disp_word ? FETCH_DISP_HIGH : after_disp;
            FETCH_DISP_HIGH:
                next_state = after_disp;
            FETCH_IMM_LOW:
                next_state = dec.imm_word ? FETCH_IMM_HIGH : FETCH_EXECUTE;
            FETCH_IMM_HIGH:
                next_state = FETCH_EXECUTE;
            default:
                next_state = step_done ? FETCH_OPCODE : FETCH_EXECUTE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active <= 1'b0;
            state <= FETCH_OPCODE;
        end
        else
        begin
            active <= 1'b1;
            // fetch states only move on a popped byte, execute waits for the step
            if (queue_pop || exec_valid)
                state <= next_state;
        end
    end

    // field capture, the overlay already placed the byte
    always_ff @(posedge clk)
    begin
        if (queue_pop)
            instr_q <= instr;
    end

endmodule

`default_nettype wire

//--- logic/opcode_decoder.sv
`default_nettype none

module opcode_decoder
(
    input  wire exu_pkg::instruction_t instr,
    output exu_pkg::decoded_t          dec
);

    // word register numbers used by the effective address table
    localparam logic [3:0] SEL_BW = 4'd3;
    localparam logic [3:0] SEL_BP = 4'd5;
    localparam logic [3:0] SEL_IX = 4'd6;
    localparam logic [3:0] SEL_IY = 4'd7;
    localparam logic [3:0] SEL_NONE = 4'b1000;

    logic [7:0] opcode;
    logic [1:0] mod;
    logic [2:0] reg_field;
    logic [2:0] rm;
    logic is_mov_rm;
    logic is_mov_imm_r;
    logic is_mov_imm_rm;
    logic direct;

    assign opcode = instr.opcode;
    assign mod = instr.modrm[7:6];
    assign reg_field = instr.modrm[5:3];
    assign rm = instr.modrm[2:0];

    // 88..8b, b0..bf and c6/c7
    assign is_mov_rm = (opcode[7:2] == 6'b100010);
    assign is_mov_imm_r = (opcode[7:4] == 4'hb);
    assign is_mov_imm_rm = (opcode[7:1] == 7'b1100011);

    // mod 00 with rm 110 is a plain 16-bit offset
    assign direct = (mod == 2'b00) && (rm == 3'b110);

    always_comb
    begin
        dec.need_modrm = is_mov_rm || is_mov_imm_rm;
        dec.need_disp = dec.need_modrm && ((mod == 2'b01) || (mod == 2'b10) || direct);
        dec.disp_word = (mod == 2'b10) || direct;
        dec.need_imm = is_mov_imm_r || is_mov_imm_rm;
        // b0..bf carry the width in bit 3, the rest in bit 0
        dec.word = is_mov_imm_r ? opcode[3] : opcode[0];
        dec.imm_word = dec.word;
        dec.mem_operand = dec.need_modrm && (mod != 2'b11);

        // direction bit set means reg is the destination
        dec.src_reg = opcode[1] ? rm : reg_field;
        if (is_mov_imm_r)
            dec.dst_reg = opcode[2:0];
        else if (is_mov_rm && opcode[1])
            dec.dst_reg = reg_field;
        else
            dec.dst_reg = rm;

        // effective address table
        case (rm)
            3'b000:  {dec.base_sel, dec.index_sel} = {SEL_BW, SEL_IX};
            3'b001:  {dec.base_sel, dec.index_sel} = {SEL_BW, SEL_IY};
            3'b010:  {dec.base_sel, dec.index_sel} = {SEL_BP, SEL_IX};
            3'b011:  {dec.base_sel, dec.index_sel} = {SEL_BP, SEL_IY};
            3'b100:  {dec.base_sel, dec.index_sel} = {SEL_NONE, SEL_IX};
            3'b101:  {dec.base_sel, dec.index_sel} = {SEL_NONE, SEL_IY};
            3'b110:  {dec.base_sel, dec.index_sel} = {direct ? SEL_NONE : SEL_BP, SEL_NONE};
            default: {dec.base_sel, dec.index_sel} = {SEL_BW, SEL_NONE};
        endcase

        // stack segment whenever bp takes part
        dec.segment = (dec.base_sel == SEL_BP) ? exu_pkg::SEG_SS : exu_pkg::SEG_DS;
    end

endmodule

`default_nettype wire

//--- logic/microcode_rom.sv
`default_nettype none

module microcode_rom
#(
    parameter int UOP_ROM_DEPTH = 512
)
(
    input  wire [7:0]          opcode,
    output exu_pkg::micro_op_t uop
);

    localparam int UOP_ADDRESS_WIDTH = $clog2(UOP_ROM_DEPTH);

    // opcode to micro-op address, then the micro-op word
    logic [UOP_ADDRESS_WIDTH-1:0] translation_rom [256];
    exu_pkg::micro_op_t rom [UOP_ROM_DEPTH];

    initial
    begin
        for (int i = 0; i < UOP_ROM_DEPTH; i++)
            rom[i] = '0;

        // r <- rm, rm <- r, rm <- imm
        rom[0] = '{exu_pkg::UOP_MOVE, 7'd0, 1'b1, exu_pkg::LOC_R, exu_pkg::LOC_RM};
        rom[1] = '{exu_pkg::UOP_MOVE, 7'd0, 1'b1, exu_pkg::LOC_RM, exu_pkg::LOC_R};
        rom[2] = '{exu_pkg::UOP_MOVE, 7'd0, 1'b1, exu_pkg::LOC_RM, exu_pkg::LOC_IMM};
        // anything not decoded ends at once without effect
        rom[3] = '{exu_pkg::UOP_NONE, 7'd0, 1'b1, exu_pkg::LOC_NONE, exu_pkg::LOC_NONE};

        for (int i = 0; i < 256; i++)
            translation_rom[i] = UOP_ADDRESS_WIDTH'(3);

        for (int i = 0; i < 2; i++)
        begin
            // 8a/8b load a register
            translation_rom[{7'b1000101, i[0]}] = UOP_ADDRESS_WIDTH'(0);
            // 88/89 store a register
            translation_rom[{7'b1000100, i[0]}] = UOP_ADDRESS_WIDTH'(1);
            // c6/c7 immediate into rm
            translation_rom[{7'b1100011, i[0]}] = UOP_ADDRESS_WIDTH'(2);
        end

        // b0..bf immediate into a register share the rm <- imm step
        for (int j = 0; j < 16; j++)
            translation_rom[{4'hb, j[3:0]}] = UOP_ADDRESS_WIDTH'(2);
    end

    assign uop = rom[translation_rom[opcode]];

endmodule

`default_nettype wire

//--- logic/register_file.sv
`default_nettype none

module register_file
(
    input  wire         clk,
    input  wire         reset,
    input  wire  [2:0]  read_a_id,
    input  wire  [2:0]  read_b_id,
    input  wire         word,
    input  wire         we,
    input  wire  [2:0]  write_id,
    input  wire  [15:0] write_data,
    output logic [15:0] read_a,
    output logic [15:0] read_b,
    output logic [15:0] base_value,
    output logic [15:0] index_value,
    input  wire  [2:0]  base_id,
    input  wire  [2:0]  index_id
);

    // aw cw dw bw sp bp ix iy
    logic [exu_pkg::DATA_WIDTH-1:0] regs [exu_pkg::REG_COUNT];

    // byte ids 0..3 are the low halves of aw..bw and 4..7 the high halves
    function automatic logic [15:0] lane_read(input logic [2:0] id, input logic is_word);
        logic [15:0] pair;
        pair = regs[{1'b0, id[1:0]}];
        if (is_word)
            return regs[id];
        return id[2] ? {8'h00, pair[15:8]} : {8'h00, pair[7:0]};
    endfunction

    // read ports follow register updates as well as id changes
    always_comb
    begin
        read_a = lane_read(read_a_id, word);
        read_b = lane_read(read_b_id, word);
    end

    // address terms are always full words
    assign base_value = regs[base_id];
    assign index_value = regs[index_id];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < exu_pkg::REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            // byte writes leave the other half alone
            if (word)
                regs[write_id] <= write_data;
            else if (write_id[2])
                regs[{1'b0, write_id[1:0]}][15:8] <= write_data[7:0];
            else
                regs[{1'b0, write_id[1:0]}][7:0] <= write_data[7:0];
        end
    end

endmodule

`default_nettype wire

//--- logic/address_generator.sv
`default_nettype none

module address_generator
(
    input  wire exu_pkg::decoded_t                  dec,
    input  wire [15:0]                              disp,
    input  wire [15:0]                              base_value,
    input  wire [15:0]                              index_value,
    input  wire exu_pkg::segment_set_t              segments,
    output logic [exu_pkg::ADDRESS_WIDTH-1:0]       phys_address
);

    logic [15:0] segment_value;
    logic [15:0] base_term;
    logic [15:0] index_term;
    logic [15:0] disp_term;
    logic [15:0] offset;

    always_comb
    begin
        case (dec.segment)
            exu_pkg::SEG_ES: segment_value = segments.es;
            exu_pkg::SEG_CS: segment_value = segments.cs;
            exu_pkg::SEG_SS: segment_value = segments.ss;
            default:         segment_value = segments.ds;
        endcase
    end

    // terms marked unused drop out of the sum
    assign base_term = dec.base_sel[3] ? 16'h0000 : base_value;
    assign index_term = dec.index_sel[3] ? 16'h0000 : index_value;
    // byte displacement is signed
    assign disp_term = !dec.need_disp ? 16'h0000 :
                       dec.disp_word ? disp : {{8{disp[7]}}, disp[7:0]};

    // effective offset wraps inside the 64k segment
    assign offset = base_term + index_term + disp_term;
    assign phys_address = {segment_value, 4'h0} + {4'h0, offset};

endmodule

`default_nettype wire

//--- logic/move_executor.sv
`default_nettype none

module move_executor
(
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                exec_valid,
    input  wire exu_pkg::micro_op_t            uop,
    input  wire exu_pkg::decoded_t             dec,
    input  wire [15:0]                         imm,
    input  wire [exu_pkg::ADDRESS_WIDTH-1:0]   phys_address,
    input  wire [15:0]                         read_a,
    input  wire [15:0]                         data_in,
    input  wire                                bus_command_done,
    output logic [2:0]                         read_a_id,
    output exu_pkg::bus_request_t              bus,
    output logic                               we,
    output logic [2:0]                         write_id,
    output logic [15:0]                        write_data,
    output logic                               word,
    output logic                               step_done
);

    logic is_move;
    logic src_mem;
    logic dst_mem;
    logic mem_access;
    // a bus command is out and not yet acknowledged
    logic waiting;
    logic [15:0] imm_value;
    logic [15:0] move_value;
    logic reg_step;
    logic bus_step;

    assign is_move = (uop.op_type == exu_pkg::UOP_MOVE);

    // rm only reaches memory when mod is not 11
    assign src_mem = is_move && (uop.src == exu_pkg::LOC_RM) && dec.mem_operand;
    assign dst_mem = is_move && (uop.dst == exu_pkg::LOC_RM) && dec.mem_operand;
    assign mem_access = src_mem || dst_mem;

    // a byte immediate has no high byte
    assign imm_value = dec.word ? imm : {8'h00, imm[7:0]};
    assign move_value = (uop.src == exu_pkg::LOC_IMM) ? imm_value : read_a;

    // register operands come straight from the decoder
    assign read_a_id = dec.src_reg;
    assign write_id = dec.dst_reg;
    assign word = dec.word;

    // register moves finish in their first execute cycle
    assign reg_step = exec_valid && !waiting && !mem_access;
    // bus moves finish on the done cycle
    assign bus_step = exec_valid && waiting && bus_command_done;

    assign write_data = src_mem ? data_in : move_value;
    assign we = is_move && (uop.dst != exu_pkg::LOC_NONE) && !dst_mem &&
                (src_mem ? bus_step : reg_step);
    assign step_done = uop.last && (reg_step || bus_step);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            waiting <= 1'b0;
            bus.command <= exu_pkg::BUS_IDLE;
        end
        else if (waiting)
        begin
            // command, address and data hold until done
            if (bus_command_done)
            begin
                waiting <= 1'b0;
                bus.command <= exu_pkg::BUS_IDLE;
            end
        end
        else if (exec_valid && mem_access)
        begin
            waiting <= 1'b1;
            bus.command <= src_mem ? exu_pkg::BUS_READ : exu_pkg::BUS_WRITE;
            bus.address <= phys_address;
            // register or immediate value for stores
            bus.write_data <= move_value;
            bus.word <= dec.word;
        end
    end

endmodule

`default_nettype wire

//--- logic/execution_unit.sv
`default_nettype none

module execution_unit
#(
    parameter int UOP_ROM_DEPTH = exu_pkg::UOP_ROM_DEPTH
)
(
    input  wire                        clk,
    input  wire                        reset,

    // prefetch queue
    input  wire [7:0]                  prefetch_data,
    input  wire                        queue_empty,
    output logic                       queue_pop,

    input  wire exu_pkg::segment_set_t segments,

    // bus to the bus control unit
    output exu_pkg::bus_request_t      bus,
    input  wire [15:0]                 data_in,
    input  wire                        bus_command_done,

    output logic                       instruction_done
);

    exu_pkg::instruction_t instr;
    exu_pkg::decoded_t dec;
    exu_pkg::micro_op_t uop;
    logic exec_valid;
    logic step_done;
    logic [2:0] read_a_id;
    logic [15:0] read_a;
    logic [15:0] base_value;
    logic [15:0] index_value;
    logic we;
    logic [2:0] write_id;
    logic [15:0] write_data;
    logic word;
    logic [exu_pkg::ADDRESS_WIDTH-1:0] phys_address;

    // one micro-op per instruction, so the step ends the instruction
    assign instruction_done = step_done;

    instruction_fetch fetch_inst
    (
        .clk(clk),
        .reset(reset),
        .prefetch_data(prefetch_data),
        .queue_empty(queue_empty),
        .dec(dec),
        .step_done(step_done),
        .queue_pop(queue_pop),
        .instr(instr),
        .exec_valid(exec_valid)
    );

    opcode_decoder decode_inst
    (
        .instr(instr),
        .dec(dec)
    );

    microcode_rom #(.UOP_ROM_DEPTH(UOP_ROM_DEPTH)) rom_inst
    (
        .opcode(instr.opcode),
        .uop(uop)
    );

    // port b watches the destination register
    register_file register_file_inst
    (
        .clk(clk),
        .reset(reset),
        .read_a_id(read_a_id),
        .read_b_id(dec.dst_reg),
        .word(word),
        .we(we),
        .write_id(write_id),
        .write_data(write_data),
        .read_a(read_a),
        .read_b(),
        .base_value(base_value),
        .index_value(index_value),
        .base_id(dec.base_sel[2:0]),
        .index_id(dec.index_sel[2:0])
    );

    address_generator address_inst
    (
        .dec(dec),
        .disp(instr.disp),
        .base_value(base_value),
        .index_value(index_value),
        .segments(segments),
        .phys_address(phys_address)
    );

    move_executor move_inst
    (
        .clk(clk),
        .reset(reset),
        .exec_valid(exec_valid),
        .uop(uop),
        .dec(dec),
        .imm(instr.imm),
        .phys_address(phys_address),
        .read_a(read_a),
        .data_in(data_in),
        .bus_command_done(bus_command_done),
        .read_a_id(read_a_id),
        .bus(bus),
        .we(we),
        .write_id(write_id),
        .write_data(write_data),
        .word(word),
        .step_done(step_done)
    );

endmodule

`default_nettype wire

//--- sim/execution_unit_tb.sv
`default_nettype none

module execution_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 8;
    // run limit per instruction byte covering stalls and bus delays
    localparam int CYCLES_PER_BYTE = 40;
    localparam int STIM_DEPTH = 512;
    // word offsets inside the stimulus image
    localparam int SEGMENT_BASE = 'h000;
    localparam int COUNT_BASE = 'h004;
    localparam int BYTE_BASE = 'h010;
    localparam int BUS_BASE = 'h100;
    localparam int BUS_FIELDS = 4;
    localparam logic [19:0] END_MARK = 20'hfffff;
    // memory model read data is the address xor this
    localparam logic [15:0] READ_PATTERN = 16'ha5c3;
    localparam logic [31:0] LFSR_SEED = 32'h5cc4e336;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic clk;
    logic reset;
    logic [7:0] prefetch_data;
    logic queue_empty;
    logic queue_pop;
    exu_pkg::segment_set_t segments;
    exu_pkg::bus_request_t bus;
    logic [15:0] data_in;
    logic bus_command_done;
    logic instruction_done;

    logic [19:0] stim [STIM_DEPTH];
    int byte_count;
    int bus_count;
    int instruction_count;
    int byte_index;
    int bus_index;
    int done_count;
    int cycle_count;
    int cycle_limit;
    logic [31:0] lfsr;
    logic [7:0] stall_bits;
    logic [7:0] delay_bits;
    // command held by the memory model and its remaining delay
    logic bus_busy;
    int done_delay;
    exu_pkg::bus_request_t issued;

    execution_unit #(.UOP_ROM_DEPTH(exu_pkg::UOP_ROM_DEPTH)) dut
    (
        .clk(clk),
        .reset(reset),
        .prefetch_data(prefetch_data),
        .queue_empty(queue_empty),
        .queue_pop(queue_pop),
        .segments(segments),
        .bus(bus),
        .data_in(data_in),
        .bus_command_done(bus_command_done),
        .instruction_done(instruction_done)
    );

    // galois step taken once per random bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0])
            shifted = shifted ^ LFSR_TAPS;
        return shifted;
    endfunction

    task automatic random_bits(input int count, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value = {value[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            stop_with_failure($sformatf("error: %s is %0h, expected %0h", name, actual, expected));
    endtask

    // a new command must match the next expected transaction
    task automatic accept_transaction();
        int base;
        exu_pkg::bus_command_t expected_command;
        if (bus_index >= bus_count)
            stop_with_failure("bus command issued after the last expected transaction");
        base = BUS_BASE + BUS_FIELDS * bus_index;
        expected_command = (stim[base] == 20'd1) ? exu_pkg::BUS_READ : exu_pkg::BUS_WRITE;
        check_value("bus.command", bus.command, expected_command);
        // a read at the wrong place fails here too
        check_value("bus.address", bus.address, stim[base + 1]);
        if (expected_command == exu_pkg::BUS_WRITE)
            check_value("bus.write_data", bus.write_data, stim[base + 2]);
        check_value("bus.word", bus.word, stim[base + 3]);
        issued = bus;
        bus_busy = 1'b1;
        // done arrives 0 to 3 cycles later
        random_bits(2, delay_bits);
        done_delay = delay_bits[1:0];
        bus_index++;
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        prefetch_data = 8'h00;
        queue_empty = 1'b1;
        data_in = 16'h0000;
        bus_command_done = 1'b0;
        lfsr = LFSR_SEED;
        byte_index = 0;
        bus_index = 0;
        done_count = 0;
        cycle_count = 0;
        bus_busy = 1'b0;
        done_delay = 0;
        issued = '0;

        for (int i = 0; i < STIM_DEPTH; i++)
            stim[i] = END_MARK;
        $readmemh("sim/exu_stimulus.txt", stim);

        segments.es = stim[SEGMENT_BASE][15:0];
        segments.cs = stim[SEGMENT_BASE + 1][15:0];
        segments.ss = stim[SEGMENT_BASE + 2][15:0];
        segments.ds = stim[SEGMENT_BASE + 3][15:0];
        instruction_count = int'(stim[COUNT_BASE]);

        // lists end at the first unwritten entry
        byte_count = 0;
        while ((BYTE_BASE + byte_count < BUS_BASE) && (stim[BYTE_BASE + byte_count] != END_MARK))
            byte_count++;
        bus_count = 0;
        while ((BUS_BASE + BUS_FIELDS * bus_count < STIM_DEPTH) &&
               (stim[BUS_BASE + BUS_FIELDS * bus_count] != END_MARK))
            bus_count++;
        cycle_limit = RESET_CYCLES + CYCLES_PER_BYTE * byte_count;

        if (byte_count == 0 || instruction_count == int'(END_MARK))
            stop_with_failure("stimulus file could not be read or holds no instructions");

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // sample between edges while waiting for the last instruction
        while (done_count < instruction_count)
        begin
            @(posedge clk);
            #2;
        end
        // one more cycle lets the memory model retire the last command
        @(posedge clk);
        #2;

        check_value("bytes popped", byte_index, byte_count);
        check_value("bus transactions", bus_index, bus_count);
        check_value("bus.command", bus.command, exu_pkg::BUS_IDLE);
        $display("TEST RESULT: PASS");
        $finish;
    end

    always #5 clk = ~clk;

    // inputs change on the falling edge only
    always @(negedge clk)
    begin
        // queue model offers the next byte and sometimes holds it back
        if (byte_index < byte_count)
        begin
            prefetch_data = stim[BYTE_BASE + byte_index][7:0];
            random_bits(2, stall_bits);
            // kept open in reset so a stray pop would show
            queue_empty = !reset && (stall_bits[1:0] == 2'b00);
        end
        else
        begin
            prefetch_data = 8'h00;
            queue_empty = 1'b1;
        end

        if (bus_command_done)
        begin
            // done was taken on the last edge so the bus is idle again
            bus_command_done = 1'b0;
            bus_busy = 1'b0;
            check_value("bus.command", bus.command, exu_pkg::BUS_IDLE);
        end
        else if (bus.command != exu_pkg::BUS_IDLE)
        begin
            if (!bus_busy)
                accept_transaction();
            else
            begin
                // request held unchanged under back-pressure
                check_value("bus.command", bus.command, issued.command);
                check_value("bus.address", bus.address, issued.address);
                check_value("bus.write_data", bus.write_data, issued.write_data);
                check_value("bus.word", bus.word, issued.word);
            end
            if (done_delay == 0)
            begin
                bus_command_done = 1'b1;
                data_in = issued.address[15:0] ^ READ_PATTERN;
            end
            else
                done_delay--;
        end
    end

    // outputs are read on the rising edge before the flops update
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
            stop_with_failure($sformatf("run did not finish within %0d cycles", cycle_limit));

        // the first edge loads the reset values
        if (reset && cycle_count > 1)
        begin
            check_value("queue_pop", queue_pop, 1'b0);
            check_value("bus.command", bus.command, exu_pkg::BUS_IDLE);
            check_value("instruction_done", instruction_done, 1'b0);
        end
        else if (!reset)
        begin
            if (queue_pop)
            begin
                if (queue_empty)
                    stop_with_failure("queue popped while the queue was empty");
                byte_index++;
            end
            if (instruction_done)
            begin
                // an instruction only ends once all its bytes are taken
                check_value("queue_pop", queue_pop, 1'b0);
                done_count++;
                if (done_count > instruction_count)
                    stop_with_failure("more instruction_done pulses than instructions");
            end
        end
    end

endmodule

`default_nettype wire

//--- all.f
logic/exu_pkg.sv
logic/instruction_fetch.sv
logic/opcode_decoder.sv
logic/microcode_rom.sv
logic/register_file.sv
logic/address_generator.sv
logic/move_executor.sv
logic/execution_unit.sv
sim/execution_unit_tb.sv

//--- Makefile
# tool, flags, top module and file list
VERILATOR  := verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
TOP        := execution_unit_tb
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# the run is judged only by the log, the simulator status is not trusted
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/exu_stimulus.txt
// @000 segments es cs ss ds, @004 instruction count, @010 instruction bytes
// @100 bus transactions: kind (1 read, 2 write), address, write data, word flag
@000
3000 f000 2468 1234
@004
12
@010
89 0e 10 00        // mov [0010], cw
b8 ef be           // mov aw, beef
89 06 00 01        // mov [0100], aw
b0 5a              // mov al, 5a
b4 3c              // mov ah, 3c
89 06 00 02        // mov [0200], aw
88 26 01 02        // mov [0201], ah
bb 00 03           // mov bw, 0300
be 20 00           // mov ix, 0020
8b 50 f0           // mov dw, [bw+ix-10]
89 16 00 04        // mov [0400], dw
bd 50 00           // mov bp, 0050
c7 86 34 12 81 7e  // mov word [bp+1234], 7e81
c6 46 fe 99        // mov byte [bp-2], 99
8b ca              // mov cw, dw
89 0e 00 05        // mov [0500], cw
88 e3              // mov bl, ah
89 1e 00 06        // mov [0600], bw
@100
2 12350 0000 1     // cw still holds its reset value
2 12440 beef 1
2 12540 3c5a 1     // al and ah merged
2 12541 003c 0     // byte store of ah
1 12650 0000 1     // 12340 + 0300 + 0020 - 0010
2 12740 8393 1     // 2650 xor a5c3
2 25904 7e81 1     // ss base 24680 + 0050 + 1234
2 246ce 0099 0
2 12840 8393 1
2 12940 033c 1
